// ==== design/dsp_settings.svh ====
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// sample lane width in bits
`define DSP_LANE_W 16
// lanes per adc word and per dac word
`define DSP_ADC_LANES 4
`define DSP_DAC_LANES 16

// channel counts
`define DSP_NDAC 4
`define DSP_NPROC 4
`define DSP_NCHAN 4

// accumulation buffer geometry
`define DSP_ACC_ADDR_W 8
`define DSP_ACC_HALF_W 32

// experiment shot counter
`define DSP_SHOT_W 32

`endif

// ==== design/dsp_pkg.sv ====
`default_nettype none
`include "dsp_settings.svh"

package dsp_pkg;

	// sample words
	typedef logic [`DSP_ADC_LANES*`DSP_LANE_W-1:0] adc_word_t;
	typedef logic [`DSP_DAC_LANES*`DSP_LANE_W-1:0] dac_word_t;

	typedef logic [`DSP_SHOT_W-1:0] shot_cnt_t;
	typedef logic [`DSP_ACC_ADDR_W-1:0] acc_addr_t;
	// real half on top, imaginary half below
	typedef logic [2*`DSP_ACC_HALF_W-1:0] acc_word_t;
	typedef logic [`DSP_NPROC-1:0] proc_vec_t;

	// baseband source codes
	typedef logic [1:0] src_sel_t;
	localparam src_sel_t sel_adc = 2'd0;
	localparam src_sel_t sel_dac_lo = 2'd1;
	localparam src_sel_t sel_dac_hi = 2'd2;
	localparam src_sel_t sel_hold = 2'd3;

	// shot sequencer states, gray-ish walk through one shot
	typedef enum logic [3:0] {
		st_idle = 4'b0000,
		st_start = 4'b0001,
		st_proc_run = 4'b0011,
		st_elem_busy = 4'b0010,
		st_more_shot = 4'b0110,
		st_shot_add = 4'b0111,
		st_done = 4'b0101
	} seq_state_t;

	// one accumulation buffer write port
	typedef struct packed {
		logic we;
		acc_addr_t addr;
		acc_word_t data;
	} acc_wr_t;

	// single-bit state measurement
	typedef struct packed {
		logic valid;
		logic state;
	} meas_t;

endpackage

`default_nettype wire

// ==== design/shot_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dsp_settings.svh"

module shot_sequencer
	import dsp_pkg::*;
(
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input shot_cnt_t nshot,
	input proc_vec_t proc_done,
	input proc_vec_t proc_idle,
	output logic proc_start,
	output logic proc_reset,
	output logic last_shot_done,
	output logic proc_done_flag,
	output shot_cnt_t shot_cnt
);

	seq_state_t state;
	seq_state_t next_state;

	// all cores done / all cores idle, one cycle behind the inputs
	logic all_done;
	logic all_idle;
	// pipelined more-shots decision
	logic more_shots;
	shot_cnt_t nshot_r;
	shot_cnt_t shot_idx;
	shot_cnt_t next_idx;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			all_done <= 1'b0;
			all_idle <= 1'b0;
			next_idx <= '0;
			more_shots <= 1'b0;
		end else begin
			all_done <= &proc_done;
			all_idle <= &proc_idle;
			next_idx <= shot_idx + 1'b1;
			// nshot of zero keeps going forever
			more_shots <= (next_idx != nshot_r) || (nshot_r == '0);
		end
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: if (stb_start) next_state = st_start;
			st_start: next_state = st_proc_run;
			st_proc_run: if (all_done) next_state = st_elem_busy;
			st_elem_busy: if (all_idle) next_state = st_more_shot;
			st_more_shot: next_state = more_shots ? st_shot_add : st_done;
			st_shot_add: next_state = st_start;
			st_done: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	// core controls registered off the next state
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			proc_start <= 1'b0;
			proc_reset <= 1'b1;
			last_shot_done <= 1'b0;
			shot_idx <= '0;
			shot_cnt <= '0;
			nshot_r <= '0;
		end else begin
			proc_start <= (next_state == st_start);
			// cores only run between start and all-done
			proc_reset <= !(next_state inside {st_start, st_proc_run});
			last_shot_done <= (next_state == st_done);
			if (state == st_idle) begin
				nshot_r <= nshot;
			end
			if (next_state == st_shot_add) begin
				// report the shot just finished
				shot_cnt <= shot_idx;
				shot_idx <= next_idx;
			end else if (next_state inside {st_idle, st_done}) begin
				shot_idx <= '0;
			end
		end
	end

	// done flag held from all-done until the next start
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			proc_done_flag <= 1'b0;
		end else if (all_done) begin
			proc_done_flag <= 1'b1;
		end else if (proc_start) begin
			proc_done_flag <= 1'b0;
		end
	end

	a_start_single: assert property (@(posedge dspif) disable iff (!rst_n)
		proc_start |=> !proc_start);

	a_done_in_state: assert property (@(posedge dspif) disable iff (!rst_n)
		last_shot_done |-> state == st_done);

endmodule

`default_nettype wire

// ==== design/baseband_select.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dsp_settings.svh"

module baseband_select
	import dsp_pkg::*;
(
	input logic dspif,
	input logic rst_n,
	input adc_word_t adc,
	input dac_word_t dac [`DSP_NDAC],
	input src_sel_t bb1_sel,
	input src_sel_t bb2_sel,
	output adc_word_t bb1,
	output adc_word_t bb2
);

	localparam int lane_w = `DSP_LANE_W;
	// dac lanes skipped per kept lane
	localparam int us_ratio = `DSP_DAC_LANES / `DSP_ADC_LANES;

	adc_word_t adc_r;
	adc_word_t dac_us [`DSP_NDAC];

	// code 3 keeps whatever was there
	function automatic adc_word_t pick_src(input src_sel_t sel, input adc_word_t cur,
		input adc_word_t adc_w, input adc_word_t dac_lo, input adc_word_t dac_hi);
		case (sel)
			sel_adc: pick_src = adc_w;
			sel_dac_lo: pick_src = dac_lo;
			sel_dac_hi: pick_src = dac_hi;
			sel_hold: pick_src = cur;
			default: pick_src = cur;
		endcase
	endfunction

	// input stage, lanes 0 4 8 12 of each dac word
	always_ff @(posedge dspif) begin
		adc_r <= adc;
		for (int i = 0; i < `DSP_NDAC; i++) begin
			for (int j = 0; j < `DSP_ADC_LANES; j++) begin
				dac_us[i][j*lane_w +: lane_w] <= dac[i][j*us_ratio*lane_w +: lane_w];
			end
		end
	end

	// bb1 from dac pair 0/1, bb2 from dac pair 2/3
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			bb1 <= '0;
			bb2 <= '0;
		end else begin
			bb1 <= pick_src(bb1_sel, bb1, adc_r, dac_us[0], dac_us[1]);
			bb2 <= pick_src(bb2_sel, bb2, adc_r, dac_us[2], dac_us[3]);
		end
	end

	a_sel_known: assert property (@(posedge dspif) disable iff (!rst_n)
		!$isunknown({bb1_sel, bb2_sel}));

endmodule

`default_nettype wire

// ==== design/acc_buffer_writer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dsp_settings.svh"

module acc_buffer_writer
	import dsp_pkg::*;
#(
	parameter int n_chan = `DSP_NCHAN
) (
	input logic dspif,
	input logic rst_n,
	input logic acc_valid [n_chan],
	input acc_word_t acc_in [n_chan],
	input logic acc_reset,
	output acc_wr_t acc_wr [n_chan],
	output meas_t meas [n_chan]
);

	// level clear of all write pointers, one stage deep
	logic acc_reset_r;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			acc_reset_r <= 1'b0;
		end else begin
			acc_reset_r <= acc_reset;
		end
	end

	for (genvar i = 0; i < n_chan; i++) begin : g_chan
		logic we_q;
		acc_addr_t addr_q;
		acc_word_t data_q;
		logic meas_valid_q;
		logic meas_state_q;
		// pointer parked on the last entry
		logic lock_last;

		assign lock_last = &addr_q;

		always_ff @(posedge dspif or negedge rst_n) begin
			if (!rst_n) begin
				we_q <= 1'b0;
				addr_q <= '0;
				meas_valid_q <= 1'b0;
			end else begin
				we_q <= acc_valid[i];
				if (acc_reset_r) begin
					addr_q <= '0;
				end else if (we_q && !lock_last) begin
					addr_q <= addr_q + 1'b1;
				end
				meas_valid_q <= we_q;
			end
		end

		always_ff @(posedge dspif) begin
			if (acc_valid[i]) begin
				data_q <= acc_in[i];
			end
			// threshold on the real axis
			meas_state_q <= data_q[2*`DSP_ACC_HALF_W-1];
		end

		assign acc_wr[i] = '{we: we_q, addr: addr_q, data: data_q};
		assign meas[i] = '{valid: meas_valid_q, state: meas_state_q};

		a_addr_sticky: assert property (@(posedge dspif) disable iff (!rst_n)
			(lock_last && !acc_reset_r) |=> lock_last);
	end

endmodule

`default_nettype wire

// ==== design/dsp_readout_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dsp_settings.svh"

module dsp_readout_top
	import dsp_pkg::*;
(
	input logic dspif,
	input logic rst_n,
	input logic stb_start,
	input shot_cnt_t nshot,
	input proc_vec_t proc_done,
	input proc_vec_t proc_idle,
	input adc_word_t adc,
	input dac_word_t dac [`DSP_NDAC],
	input src_sel_t bb1_sel,
	input src_sel_t bb2_sel,
	input logic acc_valid [`DSP_NCHAN],
	input acc_word_t acc_in [`DSP_NCHAN],
	input logic acc_reset,
	output logic proc_start,
	output logic proc_reset,
	output shot_cnt_t shot_cnt,
	output logic last_shot_done,
	output logic proc_done_flag,
	output adc_word_t bb1,
	output adc_word_t bb2,
	output acc_wr_t acc_wr [`DSP_NCHAN],
	output meas_t meas [`DSP_NCHAN]
);

	// experiment control toward the processor cores
	shot_sequencer seq_i (
		.dspif(dspif),
		.rst_n(rst_n),
		.stb_start(stb_start),
		.nshot(nshot),
		.proc_done(proc_done),
		.proc_idle(proc_idle),
		.proc_start(proc_start),
		.proc_reset(proc_reset),
		.last_shot_done(last_shot_done),
		.proc_done_flag(proc_done_flag),
		.shot_cnt(shot_cnt)
	);

	// baseband streams for the integrators
	baseband_select bb_i (
		.dspif(dspif),
		.rst_n(rst_n),
		.adc(adc),
		.dac(dac),
		.bb1_sel(bb1_sel),
		.bb2_sel(bb2_sel),
		.bb1(bb1),
		.bb2(bb2)
	);

	// integrated results into the accumulation buffers
	acc_buffer_writer #(
		.n_chan(`DSP_NCHAN)
	) acc_i (
		.dspif(dspif),
		.rst_n(rst_n),
		.acc_valid(acc_valid),
		.acc_in(acc_in),
		.acc_reset(acc_reset),
		.acc_wr(acc_wr),
		.meas(meas)
	);

endmodule

`default_nettype wire

// ==== test/dsp_readout_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dsp_settings.svh"

module dsp_readout_checker
	import dsp_pkg::*;
(
	input logic dspif,
	input logic rst_n,
	input proc_vec_t proc_done,
	input adc_word_t adc,
	input dac_word_t dac [`DSP_NDAC],
	input src_sel_t bb1_sel,
	input src_sel_t bb2_sel,
	input logic acc_valid [`DSP_NCHAN],
	input acc_word_t acc_in [`DSP_NCHAN],
	input logic acc_reset,
	input logic proc_start,
	input logic proc_reset,
	input shot_cnt_t shot_cnt,
	input logic last_shot_done,
	input logic proc_done_flag,
	input adc_word_t bb1,
	input adc_word_t bb2,
	input acc_wr_t acc_wr [`DSP_NCHAN],
	input meas_t meas [`DSP_NCHAN]
);

	int err_total;
	int test_errs;
	int tests_passed;
	int tests_failed;
	int start_seen;
	int last_seen;

	// reference pipeline for the baseband path
	adc_word_t adc_p;
	adc_word_t dac_p [`DSP_NDAC];
	adc_word_t bb1_exp;
	adc_word_t bb2_exp;
	// reference for the write ports
	logic v_p [`DSP_NCHAN];
	acc_word_t d_p [`DSP_NCHAN];
	acc_addr_t addr_exp [`DSP_NCHAN];
	logic mv_exp [`DSP_NCHAN];
	logic ms_exp [`DSP_NCHAN];
	logic rst_p;
	// all-done register and flag reference
	logic done_r;
	logic flag_exp;

	// every fourth dac lane packed low to high
	function automatic adc_word_t undersample(input dac_word_t w);
		adc_word_t r;
		for (int j = 0; j < `DSP_ADC_LANES; j++) begin
			r[j*`DSP_LANE_W +: `DSP_LANE_W] = w[4*j*`DSP_LANE_W +: `DSP_LANE_W];
		end
		return r;
	endfunction

	function automatic adc_word_t choose(input src_sel_t s, input adc_word_t cur,
		input adc_word_t a, input adc_word_t lo, input adc_word_t hi);
		if (s == 2'd0) return a;
		if (s == 2'd1) return lo;
		if (s == 2'd2) return hi;
		return cur;
	endfunction

	task automatic compare_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
			err_total++;
			test_errs++;
		end
	endtask

	always @(posedge dspif) begin
		if (!rst_n) begin
			bb1_exp <= '0;
			bb2_exp <= '0;
			rst_p <= 1'b0;
			done_r <= 1'b0;
			flag_exp <= 1'b0;
			for (int c = 0; c < `DSP_NCHAN; c++) begin
				v_p[c] <= 1'b0;
				addr_exp[c] <= '0;
				mv_exp[c] <= 1'b0;
			end
		end else begin
			compare_value("bb1", bb1, bb1_exp);
			compare_value("bb2", bb2, bb2_exp);
			compare_value("proc_done_flag", proc_done_flag, flag_exp);
			for (int c = 0; c < `DSP_NCHAN; c++) begin
				compare_value("acc_wr.we", acc_wr[c].we, v_p[c]);
				if (v_p[c]) begin
					compare_value("acc_wr.data", acc_wr[c].data, d_p[c]);
					compare_value("acc_wr.addr", acc_wr[c].addr, addr_exp[c]);
				end
				compare_value("meas.valid", meas[c].valid, mv_exp[c]);
				if (mv_exp[c]) begin
					compare_value("meas.state", meas[c].state, ms_exp[c]);
				end
			end
			if (proc_start) begin
				compare_value("proc_reset", proc_reset, 1'b0);
				// shot_cnt names the shot that just ended
				if (start_seen > 0) begin
					compare_value("shot_cnt", shot_cnt, start_seen - 1);
				end
				start_seen++;
			end
			if (last_shot_done) begin
				last_seen++;
			end
			bb1_exp <= choose(bb1_sel, bb1_exp, adc_p, dac_p[0], dac_p[1]);
			bb2_exp <= choose(bb2_sel, bb2_exp, adc_p, dac_p[2], dac_p[3]);
			for (int c = 0; c < `DSP_NCHAN; c++) begin
				if (rst_p) begin
					addr_exp[c] <= '0;
				end else if (v_p[c] && addr_exp[c] != '1) begin
					addr_exp[c] <= addr_exp[c] + 1'b1;
				end
				mv_exp[c] <= v_p[c];
				ms_exp[c] <= d_p[c][63];
				v_p[c] <= acc_valid[c];
			end
			rst_p <= acc_reset;
			flag_exp <= done_r ? 1'b1 : (proc_start ? 1'b0 : flag_exp);
			done_r <= &proc_done;
		end
		// reference input stage
		adc_p <= adc;
		for (int i = 0; i < `DSP_NDAC; i++) begin
			dac_p[i] <= undersample(dac[i]);
		end
		for (int c = 0; c < `DSP_NCHAN; c++) begin
			if (acc_valid[c]) begin
				d_p[c] <= acc_in[c];
			end
		end
	end

	task automatic begin_test();
		test_errs = 0;
		start_seen = 0;
		last_seen = 0;
	endtask

	task automatic check_reset_state();
		compare_value("proc_reset", proc_reset, 1'b1);
		compare_value("proc_start", proc_start, 1'b0);
		compare_value("last_shot_done", last_shot_done, 1'b0);
		compare_value("bb1", bb1, '0);
		compare_value("bb2", bb2, '0);
		for (int c = 0; c < `DSP_NCHAN; c++) begin
			compare_value("acc_wr.we", acc_wr[c].we, 1'b0);
			compare_value("meas.valid", meas[c].valid, 1'b0);
		end
	endtask

	task automatic expect_addr(input acc_addr_t exp);
		for (int c = 0; c < `DSP_NCHAN; c++) begin
			compare_value("acc_wr.addr", acc_wr[c].addr, exp);
		end
	endtask

	// negative counts skip that comparison
	task automatic end_test(input int num, input int exp_starts, input int exp_lasts);
		if (exp_starts >= 0 && start_seen != exp_starts) begin
			$display("test %0d saw %0d core starts but %0d were due", num, start_seen,
				exp_starts);
			test_errs++;
			err_total++;
		end
		if (exp_lasts >= 0 && last_seen != exp_lasts) begin
			$display("test %0d saw %0d experiment ends but %0d were due", num, last_seen,
				exp_lasts);
			test_errs++;
			err_total++;
		end
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %0d ok", num);
		end else begin
			tests_failed++;
			$display("test %0d failed with %0d errors", num, test_errs);
		end
	endtask

	task automatic report_counts();
		$display("tests passed %0d, tests failed %0d, errors %0d", tests_passed,
			tests_failed, err_total);
	endtask

endmodule

`default_nettype wire

// ==== test/tb_dsp_readout.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "dsp_settings.svh"

module tb_dsp_readout
	import dsp_pkg::*;
;

	logic dspif = 1'b0;
	logic rst_n;
	logic stb_start;
	shot_cnt_t nshot;
	proc_vec_t proc_done;
	proc_vec_t proc_idle;
	adc_word_t adc;
	dac_word_t dac [`DSP_NDAC];
	src_sel_t bb1_sel;
	src_sel_t bb2_sel;
	logic acc_valid [`DSP_NCHAN];
	acc_word_t acc_in [`DSP_NCHAN];
	logic acc_reset;
	logic proc_start;
	logic proc_reset;
	shot_cnt_t shot_cnt;
	logic last_shot_done;
	logic proc_done_flag;
	adc_word_t bb1;
	adc_word_t bb2;
	acc_wr_t acc_wr [`DSP_NCHAN];
	meas_t meas [`DSP_NCHAN];

	logic [15:0] lfsr_state = 16'd33771;
	logic [31:0] vec [0:63];
	int cycles = 0;
	int limit = 1000;

	always #2 dspif = ~dspif;

	dsp_readout_top dut_i (.*);

	dsp_readout_checker chk_i (.*);

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [255:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v[i] = lfsr_state[0];
		end
	endtask

	always @(posedge dspif) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: run went past %0d cycles without finishing", limit);
			$display("test failed");
			$finish;
		end
	end

	// external cores go done after 2 to 9 cycles and idle three later
	initial begin
		logic [255:0] r;
		forever begin
			@(negedge dspif);
			if (proc_start) begin
				proc_idle = '0;
				take_bits(3, r);
				repeat (2 + int'(r[2:0])) @(negedge dspif);
				proc_done = '1;
				repeat (3) begin
					@(negedge dspif);
					if (proc_reset) proc_done = '0;
				end
				proc_idle = '1;
				while (proc_done != '0) begin
					@(negedge dspif);
					if (proc_reset) proc_done = '0;
				end
			end
		end
	end

	task automatic run_record(input int num, input int kind, input int param,
		input int cnt, input int expect_val);
		logic [255:0] r;
		chk_i.begin_test();
		case (kind)
			1: chk_i.check_reset_state();
			2, 3: begin
				nshot = param;
				stb_start = 1'b1;
				@(negedge dspif);
				stb_start = 1'b0;
				if (kind == 2) begin
					while (chk_i.last_seen < expect_val) @(negedge dspif);
					repeat (6) @(negedge dspif);
				end else begin
					// free run ends by reset once the shots are done
					while (chk_i.start_seen < cnt + 1) @(negedge dspif);
					rst_n = 1'b0;
					repeat (2) @(negedge dspif);
					rst_n = 1'b1;
				end
			end
			4: begin
				bb1_sel = param;
				bb2_sel = param;
				repeat (cnt) begin
					take_bits(64, r);
					adc = r[63:0];
					for (int i = 0; i < `DSP_NDAC; i++) begin
						take_bits(256, r);
						dac[i] = r;
					end
					@(negedge dspif);
				end
				repeat (3) @(negedge dspif);
			end
			5: begin
				repeat (cnt) begin
					for (int c = 0; c < `DSP_NCHAN; c++) begin
						take_bits(64, r);
						acc_valid[c] = 1'b1;
						acc_in[c] = r[63:0];
					end
					@(negedge dspif);
				end
				for (int c = 0; c < `DSP_NCHAN; c++) acc_valid[c] = 1'b0;
				repeat (3) @(negedge dspif);
				chk_i.expect_addr(expect_val);
				acc_reset = 1'b1;
				@(negedge dspif);
				acc_reset = 1'b0;
				repeat (3) @(negedge dspif);
				chk_i.expect_addr('0);
			end
			default: begin
				$display("record %0d has unknown kind %0d", num, kind);
				chk_i.err_total++;
				chk_i.test_errs++;
			end
		endcase
		chk_i.end_test(num, kind == 2 ? cnt : -1, kind == 2 ? expect_val : (kind == 3 ? 0 : -1));
	endtask

	initial begin
		int r;
		rst_n = 1'b0;
		stb_start = 1'b0;
		nshot = '0;
		proc_done = '0;
		proc_idle = '0;
		adc = '0;
		bb1_sel = 2'd3;
		bb2_sel = 2'd3;
		acc_reset = 1'b0;
		for (int i = 0; i < `DSP_NDAC; i++) dac[i] = '0;
		for (int c = 0; c < `DSP_NCHAN; c++) begin
			acc_valid[c] = 1'b0;
			acc_in[c] = '0;
		end
		$readmemh("test/dsp_readout_vectors.txt", vec);
		limit = 0;
		for (r = 0; vec[r*5+1] != 0; r++) begin
			limit += vec[r*5+3] * 20 + 200;
		end
		repeat (2) @(negedge dspif);
		rst_n = 1'b1;
		for (r = 0; vec[r*5+1] != 0; r++) begin
			run_record(vec[r*5], vec[r*5+1], vec[r*5+2], vec[r*5+3], vec[r*5+4]);
		end
		chk_i.report_counts();
		if (chk_i.err_total == 0 && chk_i.tests_failed == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dsp_readout.f ====
+incdir+design
design/dsp_pkg.sv
design/shot_sequencer.sv
design/baseband_select.sv
design/acc_buffer_writer.sv
design/dsp_readout_top.sv
test/dsp_readout_checker.sv
test/tb_dsp_readout.sv

// ==== Bender.yml ====
package:
  name: dsp_readout

sources:
  - include_dirs:
      - design
    files:
      - design/dsp_pkg.sv
      - design/shot_sequencer.sv
      - design/baseband_select.sv
      - design/acc_buffer_writer.sv
      - design/dsp_readout_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/dsp_readout_checker.sv
      - test/tb_dsp_readout.sv

// ==== test/dsp_readout_vectors.txt ====
// test kind param count expect, all hex
// kind 1 reset, 2 shots, 3 free run, 4 baseband select, 5 accumulator writes
01 01 00 00 00
02 02 01 01 01
03 02 03 03 01
04 02 05 05 01
05 03 00 06 00
06 04 00 08 00
07 04 01 08 00
08 04 02 08 00
09 04 03 08 00
0a 05 00 104 ff
00 00 00 00 00
